// ==== files.f ====
logic/board_io_pkg.sv
logic/dev_bus_if.sv
logic/debounce_bank.sv
logic/board_regs.sv
logic/irq_ctrl.sv
logic/axil_dev_bridge.sv
logic/board_io_top.sv
testbench/board_io_checker.sv
testbench/tb_board_io.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_board_io
RTL_TOP   ?= board_io_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_board_io.sv ====
`timescale 1ns/1ps

module tb_board_io;

	localparam int DEB     = 8;
	localparam int HOLD    = 4 * DEB;
	localparam int TIMEOUT = 100;

	logic        clk_cpu;
	logic        arst_n_i;
	logic [11:0] s_awaddr_i;
	logic        s_awvalid_i;
	logic        s_awready_o;
	logic [31:0] s_wdata_i;
	logic [3:0]  s_wstrb_i;
	logic        s_wvalid_i;
	logic        s_wready_o;
	logic [1:0]  s_bresp_o;
	logic        s_bvalid_o;
	logic        s_bready_i;
	logic [11:0] s_araddr_i;
	logic        s_arvalid_i;
	logic        s_arready_o;
	logic [31:0] s_rdata_o;
	logic [1:0]  s_rresp_o;
	logic        s_rvalid_o;
	logic        s_rready_i;
	logic [7:0]  switch_i;
	logic [3:0]  btn_i;
	logic [7:0]  led_o;
	logic        irq_o;
	logic [3:0]  bad_slot;

	board_io_top #(.DEBOUNCE_CYCLES(DEB)) dut_i (.*);

	board_io_checker chk_i (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #5 clk_cpu = ~clk_cpu;
	end

	function automatic logic [11:0] addr_of(input logic [3:0] slot, input logic [5:0] idx);
		return {slot, idx, 2'b00};
	endfunction

	task automatic abort(input string msg);
		$display("timeout: %s", msg);
		$display(">>> FAIL");
		$finish;
	endtask

	task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		int d;
		d = $urandom_range(0, 5);
		@(posedge clk_cpu);
		#1;
		s_awaddr_i = addr;
		s_wdata_i = data;
		s_wstrb_i = strb;
		s_awvalid_i = 1'b1;
		s_wvalid_i = 1'b1;
		n = 0;
		@(negedge clk_cpu);
		while (!s_awready_o) begin
			n++;
			if (n > TIMEOUT)
				abort("write address was never accepted");
			@(negedge clk_cpu);
		end
		@(posedge clk_cpu);
		#1;
		s_awvalid_i = 1'b0;
		s_wvalid_i = 1'b0;
		// hold off bready to stress the response hold
		repeat (d) begin
			@(posedge clk_cpu);
			#1;
		end
		s_bready_i = 1'b1;
		n = 0;
		@(negedge clk_cpu);
		while (!s_bvalid_o) begin
			n++;
			if (n > TIMEOUT)
				abort("write response never arrived");
			@(negedge clk_cpu);
		end
		@(posedge clk_cpu);
		#1;
		s_bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [11:0] addr);
		int n;
		int d;
		d = $urandom_range(0, 5);
		@(posedge clk_cpu);
		#1;
		s_araddr_i = addr;
		s_arvalid_i = 1'b1;
		n = 0;
		@(negedge clk_cpu);
		while (!s_arready_o) begin
			n++;
			if (n > TIMEOUT)
				abort("read address was never accepted");
			@(negedge clk_cpu);
		end
		@(posedge clk_cpu);
		#1;
		s_arvalid_i = 1'b0;
		repeat (d) begin
			@(posedge clk_cpu);
			#1;
		end
		s_rready_i = 1'b1;
		n = 0;
		@(negedge clk_cpu);
		while (!s_rvalid_o) begin
			n++;
			if (n > TIMEOUT)
				abort("read data never arrived");
			@(negedge clk_cpu);
		end
		@(posedge clk_cpu);
		#1;
		s_rready_i = 1'b0;
	endtask

	task automatic apply_inputs(input logic [7:0] sw, input logic [3:0] btn);
		chk_i.unsettle();
		@(posedge clk_cpu);
		#1;
		switch_i = sw;
		btn_i = btn;
		repeat (HOLD) @(posedge clk_cpu);
		chk_i.settle(sw, btn);
	endtask

	// short pulse that the debouncer must swallow
	task automatic glitch_inputs(input int len);
		logic [7:0] sw;
		logic [3:0] btn;
		sw = switch_i;
		btn = btn_i;
		chk_i.unsettle();
		@(posedge clk_cpu);
		#1;
		switch_i = ~sw;
		btn_i = ~btn;
		repeat (len) @(posedge clk_cpu);
		#1;
		switch_i = sw;
		btn_i = btn;
		repeat (HOLD) @(posedge clk_cpu);
		chk_i.settle(sw, btn);
	endtask

	task automatic read_all();
		axi_read(addr_of(4'd0, 6'd0));
		axi_read(addr_of(4'd0, 6'd1));
		axi_read(addr_of(4'd0, 6'd2));
		axi_read(addr_of(4'd1, 6'd0));
		axi_read(addr_of(4'd1, 6'd1));
	endtask

	initial begin
		void'($urandom(32'h6833));
		arst_n_i = 1'b0;
		s_awaddr_i = '0;
		s_awvalid_i = 1'b0;
		s_wdata_i = '0;
		s_wstrb_i = '0;
		s_wvalid_i = 1'b0;
		s_bready_i = 1'b0;
		s_araddr_i = '0;
		s_arvalid_i = 1'b0;
		s_rready_i = 1'b0;
		switch_i = '0;
		btn_i = '0;
		bad_slot = '0;
		repeat (10) @(posedge clk_cpu);
		#1;
		arst_n_i = 1'b1;

		chk_i.begin_test("reset_values");
		read_all();
		chk_i.end_test();

		chk_i.begin_test("led_register");
		repeat (12) begin
			axi_write(addr_of(4'd0, 6'd2), $urandom, 4'($urandom_range(0, 15)));
			axi_read(addr_of(4'd0, 6'd2));
		end
		chk_i.end_test();

		chk_i.begin_test("debounced_reads");
		repeat (5) begin
			apply_inputs(8'($urandom), 4'($urandom));
			read_all();
		end
		glitch_inputs(3);
		read_all();
		chk_i.end_test();

		chk_i.begin_test("interrupts");
		axi_write(addr_of(4'd1, 6'd0), 32'h3, 4'h1);
		apply_inputs(switch_i, 4'h0);
		axi_write(addr_of(4'd1, 6'd0), 32'h3, 4'h1);
		axi_read(addr_of(4'd1, 6'd0));
		apply_inputs(switch_i, 4'h1);
		axi_read(addr_of(4'd1, 6'd0));
		apply_inputs(switch_i ^ 8'h80, btn_i);
		axi_read(addr_of(4'd1, 6'd0));
		repeat (6) begin
			axi_write(addr_of(4'd1, 6'd1), $urandom, 4'h1);
			axi_read(addr_of(4'd1, 6'd1));
			axi_write(addr_of(4'd1, 6'd0), 32'($urandom_range(0, 3)), 4'h1);
			axi_read(addr_of(4'd1, 6'd0));
			apply_inputs(8'($urandom), 4'($urandom));
		end
		chk_i.end_test();

		chk_i.begin_test("decode_error");
		repeat (8) begin
			bad_slot = 4'($urandom_range(2, 15));
			axi_write(addr_of(bad_slot, 6'($urandom)), $urandom, 4'hf);
			bad_slot = 4'($urandom_range(2, 15));
			axi_read(addr_of(bad_slot, 6'($urandom)));
		end
		read_all();
		chk_i.end_test();

		chk_i.report();
		if (chk_i.err_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== testbench/board_io_checker.sv ====
`timescale 1ns/1ps

module board_io_checker (
	input logic        clk_cpu,
	input logic        arst_n_i,
	input logic [11:0] s_awaddr_i,
	input logic        s_awvalid_i,
	input logic [31:0] s_wdata_i,
	input logic [3:0]  s_wstrb_i,
	input logic        s_wvalid_i,
	input logic        s_awready_o,
	input logic        s_wready_o,
	input logic [1:0]  s_bresp_o,
	input logic        s_bvalid_o,
	input logic        s_bready_i,
	input logic [11:0] s_araddr_i,
	input logic        s_arvalid_i,
	input logic        s_arready_o,
	input logic [31:0] s_rdata_o,
	input logic [1:0]  s_rresp_o,
	input logic        s_rvalid_o,
	input logic        s_rready_i,
	input logic [7:0]  led_o,
	input logic        irq_o
);

	// model of the register state
	logic [7:0]  m_led;
	logic [1:0]  m_mask;
	logic [1:0]  m_pend;
	logic [7:0]  m_sw;
	logic [3:0]  m_btn;
	logic        m_bvalid;
	logic        m_rvalid;
	logic        wr_acc;
	logic        rd_acc;
	logic        settled;
	logic [31:0] exp_rdata;
	logic [1:0]  exp_rresp;
	logic [1:0]  exp_bresp;
	string       cur_test;
	int          test_errs;
	int          err_count;
	int          tests_run;
	int          tests_failed;

	initial begin
		m_led = '0;
		m_mask = '0;
		m_pend = '0;
		m_sw = '0;
		m_btn = '0;
		m_bvalid = 1'b0;
		m_rvalid = 1'b0;
		wr_acc = 1'b0;
		rd_acc = 1'b0;
		settled = 1'b1;
		exp_rdata = '0;
		exp_rresp = '0;
		exp_bresp = '0;
		cur_test = "none";
		test_errs = 0;
		err_count = 0;
		tests_run = 0;
		tests_failed = 0;
	end

	function automatic logic mapped(input logic [11:0] a);
		return (a[11:8] == 4'd0) || (a[11:8] == 4'd1);
	endfunction

	function automatic logic [31:0] model_read(input logic [11:0] a);
		logic [31:0] v;
		v = '0;
		if (a[11:8] == 4'd0) begin
			case (a[7:2])
				6'd0: v[7:0] = m_sw;
				6'd1: v[3:0] = m_btn;
				6'd2: v[7:0] = m_led;
				default: v = '0;
			endcase
		end else if (a[11:8] == 4'd1) begin
			case (a[7:2])
				6'd0: v[1:0] = m_pend;
				6'd1: v[1:0] = m_mask;
				default: v = '0;
			endcase
		end
		return v;
	endfunction

	task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("[FAIL] %s %s: expected %h actual %h", cur_test, what, exp, act);
			test_errs++;
			err_count++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errs == 0) begin
			$display("test %s: ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", cur_test, test_errs);
		end
	endtask

	// pending bits unknown while inputs move
	task automatic unsettle();
		settled = 1'b0;
	endtask

	task automatic settle(input logic [7:0] sw, input logic [3:0] btn);
		if (|(btn & ~m_btn))
			m_pend[0] = 1'b1;
		if (sw != m_sw)
			m_pend[1] = 1'b1;
		m_sw = sw;
		m_btn = btn;
		settled = 1'b1;
	endtask

	task automatic report();
		$display("summary: %0d tests, %0d failed, %0d mismatches",
			tests_run, tests_failed, err_count);
	endtask

	// falling-edge sampling of the DUT ports
	always @(negedge clk_cpu) begin
		if (arst_n_i) begin
			wr_acc = s_awvalid_i && s_wvalid_i && !m_bvalid && !m_rvalid;
			rd_acc = s_arvalid_i && !wr_acc && !m_bvalid && !m_rvalid;
			compare("awready", 32'(wr_acc), 32'(s_awready_o));
			compare("wready", 32'(wr_acc), 32'(s_wready_o));
			compare("arready", 32'(rd_acc), 32'(s_arready_o));
			compare("bvalid", 32'(m_bvalid), 32'(s_bvalid_o));
			compare("rvalid", 32'(m_rvalid), 32'(s_rvalid_o));
			compare("led_o", 32'(m_led), 32'(led_o));
			if (settled)
				compare("irq_o", 32'(|(m_pend & m_mask)), 32'(irq_o));
			if (m_bvalid)
				compare("bresp", 32'(exp_bresp), 32'(s_bresp_o));
			if (m_rvalid) begin
				compare("rdata", exp_rdata, s_rdata_o);
				compare("rresp", 32'(exp_rresp), 32'(s_rresp_o));
			end
			if (m_bvalid && s_bready_i)
				m_bvalid = 1'b0;
			if (m_rvalid && s_rready_i)
				m_rvalid = 1'b0;
			if (wr_acc) begin
				m_bvalid = 1'b1;
				exp_bresp = mapped(s_awaddr_i) ? 2'd0 : 2'd3;
				if (s_awaddr_i[11:8] == 4'd0 && s_awaddr_i[7:2] == 6'd2 && s_wstrb_i[0])
					m_led = s_wdata_i[7:0];
				if (s_awaddr_i[11:8] == 4'd1 && s_wstrb_i[0]) begin
					if (s_awaddr_i[7:2] == 6'd0)
						m_pend = m_pend & ~s_wdata_i[1:0];
					else if (s_awaddr_i[7:2] == 6'd1)
						m_mask = s_wdata_i[1:0];
				end
			end
			if (rd_acc) begin
				m_rvalid = 1'b1;
				exp_rdata = model_read(s_araddr_i);
				exp_rresp = mapped(s_araddr_i) ? 2'd0 : 2'd3;
			end
		end
	end

endmodule

// ==== logic/board_io_top.sv ====
`timescale 1ns/1ps

module board_io_top #(
	parameter int DEBOUNCE_CYCLES = 1000
) (
	input  logic                                   clk_cpu,
	input  logic                                   arst_n_i,
	input  logic [board_io_pkg::AXIL_ADDR_W-1:0]   s_awaddr_i,
	input  logic                                   s_awvalid_i,
	output logic                                   s_awready_o,
	input  logic [board_io_pkg::DATA_W-1:0]        s_wdata_i,
	input  logic [board_io_pkg::DATA_W/8-1:0]      s_wstrb_i,
	input  logic                                   s_wvalid_i,
	output logic                                   s_wready_o,
	output logic [1:0]                             s_bresp_o,
	output logic                                   s_bvalid_o,
	input  logic                                   s_bready_i,
	input  logic [board_io_pkg::AXIL_ADDR_W-1:0]   s_araddr_i,
	input  logic                                   s_arvalid_i,
	output logic                                   s_arready_o,
	output logic [board_io_pkg::DATA_W-1:0]        s_rdata_o,
	output logic [1:0]                             s_rresp_o,
	output logic                                   s_rvalid_o,
	input  logic                                   s_rready_i,
	input  logic [board_io_pkg::N_SWITCH-1:0]      switch_i,
	input  logic [board_io_pkg::N_BUTTON-1:0]      btn_i,
	output logic [7:0]                             led_o,
	output logic                                   irq_o
);

	logic [board_io_pkg::N_IRQ-1:0] board_event;

	dev_bus_if board_bus ();
	dev_bus_if irq_bus ();

	axil_dev_bridge u_bridge (
		.clk_cpu     (clk_cpu),
		.arst_n_i    (arst_n_i),
		.s_awaddr_i  (s_awaddr_i),
		.s_awvalid_i (s_awvalid_i),
		.s_awready_o (s_awready_o),
		.s_wdata_i   (s_wdata_i),
		.s_wstrb_i   (s_wstrb_i),
		.s_wvalid_i  (s_wvalid_i),
		.s_wready_o  (s_wready_o),
		.s_bresp_o   (s_bresp_o),
		.s_bvalid_o  (s_bvalid_o),
		.s_bready_i  (s_bready_i),
		.s_araddr_i  (s_araddr_i),
		.s_arvalid_i (s_arvalid_i),
		.s_arready_o (s_arready_o),
		.s_rdata_o   (s_rdata_o),
		.s_rresp_o   (s_rresp_o),
		.s_rvalid_o  (s_rvalid_o),
		.s_rready_i  (s_rready_i),
		.board_bus   (board_bus.bridge),
		.irq_bus     (irq_bus.bridge)
	);

	board_regs #(
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_board_regs (
		.clk_cpu  (clk_cpu),
		.arst_n_i (arst_n_i),
		.switch_i (switch_i),
		.btn_i    (btn_i),
		.bus      (board_bus.device),
		.led_o    (led_o),
		.event_o  (board_event)
	);

	irq_ctrl u_irq_ctrl (
		.clk_cpu  (clk_cpu),
		.arst_n_i (arst_n_i),
		.event_i  (board_event),
		.bus      (irq_bus.device),
		.irq_o    (irq_o)
	);

endmodule

// ==== logic/axil_dev_bridge.sv ====
`timescale 1ns/1ps

module axil_dev_bridge (
	input  logic                                   clk_cpu,
	input  logic                                   arst_n_i,
	input  logic [board_io_pkg::AXIL_ADDR_W-1:0]   s_awaddr_i,
	input  logic                                   s_awvalid_i,
	output logic                                   s_awready_o,
	input  logic [board_io_pkg::DATA_W-1:0]        s_wdata_i,
	input  logic [board_io_pkg::DATA_W/8-1:0]      s_wstrb_i,
	input  logic                                   s_wvalid_i,
	output logic                                   s_wready_o,
	output logic [1:0]                             s_bresp_o,
	output logic                                   s_bvalid_o,
	input  logic                                   s_bready_i,
	input  logic [board_io_pkg::AXIL_ADDR_W-1:0]   s_araddr_i,
	input  logic                                   s_arvalid_i,
	output logic                                   s_arready_o,
	output logic [board_io_pkg::DATA_W-1:0]        s_rdata_o,
	output logic [1:0]                             s_rresp_o,
	output logic                                   s_rvalid_o,
	input  logic                                   s_rready_i,
	dev_bus_if.bridge                              board_bus,
	dev_bus_if.bridge                              irq_bus
);

	logic                                  bvalid_q;
	logic                                  rvalid_q;
	board_io_pkg::resp_e                   bresp_q;
	board_io_pkg::resp_e                   rresp_q;
	logic [board_io_pkg::DATA_W-1:0]       rdata_q;

	logic                                  idle;
	logic                                  wr_go;
	logic                                  rd_go;
	logic [board_io_pkg::AXIL_ADDR_W-1:0]  addr;
	logic [3:0]                            slot;
	logic                                  sel_board;
	logic                                  sel_irq;
	logic                                  mapped;
	logic [board_io_pkg::DATA_W-1:0]       dev_rdata;
	board_io_pkg::resp_e                   resp;

	// one access at a time, write has priority
	assign idle  = !bvalid_q && !rvalid_q;
	assign wr_go = idle && s_awvalid_i && s_wvalid_i;
	assign rd_go = idle && !wr_go && s_arvalid_i;

	assign s_awready_o = wr_go;
	assign s_wready_o  = wr_go;
	assign s_arready_o = rd_go;

	assign addr      = wr_go ? s_awaddr_i : s_araddr_i;
	assign slot      = addr[board_io_pkg::SLOT_MSB:board_io_pkg::SLOT_LSB];
	assign sel_board = (slot == board_io_pkg::SLOT_BOARD);
	assign sel_irq   = (slot == board_io_pkg::SLOT_IRQ);
	assign mapped    = sel_board || sel_irq;
	assign resp      = mapped ? board_io_pkg::RESP_OKAY : board_io_pkg::RESP_DECERR;

	assign board_bus.req     = (wr_go || rd_go) && sel_board;
	assign board_bus.we      = wr_go;
	assign board_bus.reg_idx = addr[7:2];
	assign board_bus.wdata   = s_wdata_i;
	assign board_bus.wstrb   = s_wstrb_i;

	assign irq_bus.req     = (wr_go || rd_go) && sel_irq;
	assign irq_bus.we      = wr_go;
	assign irq_bus.reg_idx = addr[7:2];
	assign irq_bus.wdata   = s_wdata_i;
	assign irq_bus.wstrb   = s_wstrb_i;

	// unmapped slots read as zero
	always_comb begin
		dev_rdata = '0;
		if (sel_board)
			dev_rdata = board_bus.rdata;
		else if (sel_irq)
			dev_rdata = irq_bus.rdata;
	end

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr_go)
				bvalid_q <= 1'b1;
			else if (s_bready_i)
				bvalid_q <= 1'b0;
			if (rd_go)
				rvalid_q <= 1'b1;
			else if (s_rready_i)
				rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (wr_go)
			bresp_q <= resp;
		if (rd_go) begin
			rresp_q <= resp;
			rdata_q <= dev_rdata;
		end
	end

	assign s_bvalid_o = bvalid_q;
	assign s_bresp_o  = bresp_q;
	assign s_rvalid_o = rvalid_q;
	assign s_rresp_o  = rresp_q;
	assign s_rdata_o  = rdata_q;

	a_bvalid_hold: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o));

	a_rvalid_hold: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o));

	a_req_onehot: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		!(board_bus.req && irq_bus.req));

endmodule

// ==== logic/irq_ctrl.sv ====
`timescale 1ns/1ps

module irq_ctrl (
	input  logic                              clk_cpu,
	input  logic                              arst_n_i,
	input  logic [board_io_pkg::N_IRQ-1:0]    event_i,
	dev_bus_if.device                         bus,
	output logic                              irq_o
);

	logic [board_io_pkg::N_IRQ-1:0]  pending_q;
	logic [board_io_pkg::N_IRQ-1:0]  mask_q;
	logic [board_io_pkg::N_IRQ-1:0]  clr;
	logic                            wr_low;
	logic                            mask_wr;

	// only byte 0 carries interrupt bits
	assign wr_low  = bus.req && bus.we && bus.wstrb[0];
	assign mask_wr = wr_low && (bus.reg_idx == board_io_pkg::REG_MASK);
	assign clr     = (wr_low && (bus.reg_idx == board_io_pkg::REG_PENDING)) ?
		bus.wdata[board_io_pkg::N_IRQ-1:0] : '0;

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pending_q <= '0;
			mask_q    <= '0;
		end else begin
			// a new event beats a clear in the same cycle
			pending_q <= (pending_q & ~clr) | event_i;
			if (mask_wr)
				mask_q <= bus.wdata[board_io_pkg::N_IRQ-1:0];
		end
	end

	always_comb begin
		bus.rdata = '0;
		case (bus.reg_idx)
			board_io_pkg::REG_PENDING: bus.rdata[board_io_pkg::N_IRQ-1:0] = pending_q;
			board_io_pkg::REG_MASK:    bus.rdata[board_io_pkg::N_IRQ-1:0] = mask_q;
			default:                   bus.rdata = '0;
		endcase
	end

	assign irq_o = |(pending_q & mask_q);

	a_irq_masked: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		(mask_q == '0) |-> !irq_o);

endmodule

// ==== logic/board_regs.sv ====
`timescale 1ns/1ps

module board_regs #(
	parameter int DEBOUNCE_CYCLES = 1000
) (
	input  logic                                clk_cpu,
	input  logic                                arst_n_i,
	input  logic [board_io_pkg::N_SWITCH-1:0]   switch_i,
	input  logic [board_io_pkg::N_BUTTON-1:0]   btn_i,
	dev_bus_if.device                           bus,
	output logic [7:0]                          led_o,
	output logic [board_io_pkg::N_IRQ-1:0]      event_o
);

	logic [board_io_pkg::N_SWITCH-1:0]  sw_clean;
	logic [board_io_pkg::N_BUTTON-1:0]  btn_clean;
	logic [board_io_pkg::N_SWITCH-1:0]  sw_prev_q;
	logic [board_io_pkg::N_BUTTON-1:0]  btn_prev_q;
	logic [7:0]                         led_q;
	logic                               led_wr;

	debounce_bank #(
		.T               (logic [board_io_pkg::N_SWITCH-1:0]),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_switch_db (
		.clk_cpu  (clk_cpu),
		.arst_n_i (arst_n_i),
		.raw_i    (switch_i),
		.clean_o  (sw_clean)
	);

	debounce_bank #(
		.T               (logic [board_io_pkg::N_BUTTON-1:0]),
		.DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
	) u_button_db (
		.clk_cpu  (clk_cpu),
		.arst_n_i (arst_n_i),
		.raw_i    (btn_i),
		.clean_o  (btn_clean)
	);

	assign led_wr = bus.req && bus.we && (bus.reg_idx == board_io_pkg::REG_LED) && bus.wstrb[0];

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			led_q      <= '0;
			sw_prev_q  <= '0;
			btn_prev_q <= '0;
			event_o    <= '0;
		end else begin
			if (led_wr)
				led_q <= bus.wdata[7:0];
			sw_prev_q  <= sw_clean;
			btn_prev_q <= btn_clean;
			// press edges only, release is ignored
			event_o[board_io_pkg::IRQ_BUTTON] <= |(btn_clean & ~btn_prev_q);
			event_o[board_io_pkg::IRQ_SWITCH] <= (sw_clean != sw_prev_q);
		end
	end

	always_comb begin
		bus.rdata = '0;
		case (bus.reg_idx)
			board_io_pkg::REG_SWITCH: bus.rdata[board_io_pkg::N_SWITCH-1:0] = sw_clean;
			board_io_pkg::REG_BUTTON: bus.rdata[board_io_pkg::N_BUTTON-1:0] = btn_clean;
			board_io_pkg::REG_LED:    bus.rdata[7:0] = led_q;
			default:                  bus.rdata = '0;
		endcase
	end

	assign led_o = led_q;

endmodule

// ==== logic/debounce_bank.sv ====
`timescale 1ns/1ps

module debounce_bank #(
	parameter type T               = logic [7:0],
	parameter int  DEBOUNCE_CYCLES = 1000
) (
	input  logic clk_cpu,
	input  logic arst_n_i,
	input  T     raw_i,
	output T     clean_o
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	T                 sample_q;
	logic [CNT_W-1:0] cnt_q;
	logic             at_limit;

	assign at_limit = (cnt_q == CNT_W'(DEBOUNCE_CYCLES));

	// shared stability counter for the whole vector
	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sample_q <= '0;
			cnt_q    <= '0;
			clean_o  <= '0;
		end else begin
			sample_q <= raw_i;
			if (raw_i != sample_q)
				cnt_q <= '0;
			else if (!at_limit)
				cnt_q <= cnt_q + CNT_W'(1);
			if (at_limit)
				clean_o <= sample_q;
		end
	end

	a_clean_at_limit: assert property (@(posedge clk_cpu) disable iff (!arst_n_i)
		$changed(clean_o) |-> $past(at_limit));

endmodule

// ==== logic/dev_bus_if.sv ====
`timescale 1ns/1ps

// single-cycle device bus, device answers in the same cycle
interface dev_bus_if;

	logic                               req;
	logic                               we;
	board_io_pkg::reg_idx_t             reg_idx;
	logic [board_io_pkg::DATA_W-1:0]    wdata;
	logic [board_io_pkg::DATA_W/8-1:0]  wstrb;
	logic [board_io_pkg::DATA_W-1:0]    rdata;

	modport bridge (
		output req,
		output we,
		output reg_idx,
		output wdata,
		output wstrb,
		input  rdata
	);

	modport device (
		input  req,
		input  we,
		input  reg_idx,
		input  wdata,
		input  wstrb,
		output rdata
	);

endinterface

// ==== logic/board_io_pkg.sv ====
package board_io_pkg;

	// bus geometry
	localparam int AXIL_ADDR_W = 12;
	localparam int DATA_W      = 32;
	localparam int SLOT_MSB    = 11;
	localparam int SLOT_LSB    = 8;

	// word index within a slot, address bits 7:2
	typedef logic [5:0] reg_idx_t;

	typedef enum logic [3:0] {
		SLOT_BOARD = 4'd0,
		SLOT_IRQ   = 4'd1
	} slot_e;

	// board register map
	localparam reg_idx_t REG_SWITCH = 6'd0;
	localparam reg_idx_t REG_BUTTON = 6'd1;
	localparam reg_idx_t REG_LED    = 6'd2;

	// interrupt controller register map
	localparam reg_idx_t REG_PENDING = 6'd0;
	localparam reg_idx_t REG_MASK    = 6'd1;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_DECERR = 2'd3
	} resp_e;

	localparam int N_IRQ      = 2;
	localparam int IRQ_BUTTON = 0;
	localparam int IRQ_SWITCH = 1;

	localparam int N_SWITCH = 8;
	localparam int N_BUTTON = 4;

endpackage
